//--- compile.f
+incdir+.
uop_pkg.sv
exec_pkg.sv
cdb_if.sv
intm_rs.sv
fu_md.sv
prf.sv
cdb_arb.sv
intm_top.sv
intm_properties.sv
tb_intm.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module tb_intm
./obj_dir/Vtb_intm | tee /dev/stderr | grep -qx "TB PASSED"

//--- tb_intm.sv
`timescale 1ns/1ns
`include "intm_cfg.svh"

module tb_intm;

    localparam int N_UOPS = 400;
    localparam int LANES  = `INTM_ID_WIDTH;
    localparam int DEPTH  = `INTM_RS_DEPTH;
    localparam int NREG   = `INTM_PRF_REGS;
    localparam int NROB   = `INTM_ROB_SIZE;
    localparam uop_pkg::xlen_t MIN_INT = 32'h8000_0000;
    localparam uop_pkg::xlen_t ONES    = 32'hffff_ffff;

    logic             clk, rst;
    logic             ds_valid   [LANES];
    uop_pkg::rob_t    ds_rob     [LANES];
    uop_pkg::phy_t    ds_rd_phy  [LANES];
    uop_pkg::arch_t   ds_rd_arch [LANES];
    uop_pkg::phy_t    ds_rs1_phy [LANES];
    logic             ds_rs1_rdy [LANES];
    uop_pkg::phy_t    ds_rs2_phy [LANES];
    logic             ds_rs2_rdy [LANES];
    exec_pkg::md_op_t ds_op      [LANES];
    logic             ds_ready, ext_valid, ext_grant, cdb_valid;
    uop_pkg::phy_t    ext_phy, cdb_phy;
    uop_pkg::rob_t    ext_rob, cdb_rob;
    uop_pkg::arch_t   ext_arch, cdb_arch;
    uop_pkg::xlen_t   ext_value, cdb_value;

    // reference model state
    uop_pkg::xlen_t   m_val    [NREG];
    bit               m_wr     [NREG];
    bit               m_busy   [NREG];
    int               m_rd_cnt [NREG];
    bit               rob_used [NROB];
    exec_pkg::md_op_t sb_op    [NROB];
    uop_pkg::phy_t    sb_s1    [NROB];
    uop_pkg::phy_t    sb_s2    [NROB];
    uop_pkg::phy_t    sb_rd    [NROB];
    uop_pkg::arch_t   sb_arch  [NROB];
    int               n_built, n_done, n_ext_sent, n_ext_done, n_acc;
    bit               saw_low, hit_div0, hit_ovf;

    intm_top UUT (
        .clk, .rst, .ds_valid, .ds_rob, .ds_rd_phy, .ds_rd_arch, .ds_rs1_phy,
        .ds_rs1_rdy, .ds_rs2_phy, .ds_rs2_rdy, .ds_op, .ds_ready,
        .ext_valid, .ext_phy, .ext_rob, .ext_arch, .ext_value, .ext_grant,
        .cdb_valid, .cdb_phy, .cdb_rob, .cdb_arch, .cdb_value
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // bound scales with the uop count and allows serialized divides
    initial begin
        #(N_UOPS * 40 * 40 + 20 * 40);
        fail_run("timeout: not all dispatched uops completed on the CDB");
    end

    task automatic fail_run(string what);
        $display("%s", what);
        $display("TB FAILED");
        $fatal(1, "run stopped");
    endtask

    // ------------------------------
    // compare tasks
    // ------------------------------

    task automatic check_value(string name, uop_pkg::xlen_t exp, uop_pkg::xlen_t act);
        if (exp !== act) fail_run($sformatf("[ERROR] %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_tag(string name, uop_pkg::rob_t exp, uop_pkg::rob_t act);
        if (exp !== act) fail_run($sformatf("[ERROR] %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_phy(string name, uop_pkg::phy_t exp, uop_pkg::phy_t act);
        if (exp !== act) fail_run($sformatf("[ERROR] %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_arch(string name, uop_pkg::arch_t exp, uop_pkg::arch_t act);
        if (exp !== act) fail_run($sformatf("[ERROR] %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        if (exp !== act) fail_run($sformatf("[ERROR] %s expected %b actual %b", name, exp, act));
    endtask

    // ------------------------------
    // reference arithmetic
    // ------------------------------

    function automatic uop_pkg::xlen_t md_result(exec_pkg::md_op_t op, uop_pkg::xlen_t a,
                                                 uop_pkg::xlen_t b);
        longint   sa, sb;
        logic [63:0] p;
        bit       ovf;
        sa  = longint'($signed(a));
        sb  = longint'($signed(b));
        ovf = (a == MIN_INT) && (b == ONES);
        case (op)
            exec_pkg::MUL: begin
                p = sa * sb;
                return p[31:0];
            end
            exec_pkg::MULH: begin
                p = sa * sb;
                return p[63:32];
            end
            exec_pkg::MULHU: begin
                p = {32'b0, a} * {32'b0, b};
                return p[63:32];
            end
            exec_pkg::DIV:   return (b == 0) ? ONES : (ovf ? a : uop_pkg::xlen_t'(sa / sb));
            exec_pkg::REM:   return (b == 0) ? a : (ovf ? '0 : uop_pkg::xlen_t'(sa % sb));
            exec_pkg::DIVU:  return (b == 0) ? ONES : a / b;
            default:         return (b == 0) ? a : a % b;
        endcase
    endfunction

    function automatic logic src_ready(int r);
        return m_wr[r] && !m_busy[r];
    endfunction

    // mode 0 picks a usable source, 1 a free unwritten register and 2 any free one
    function automatic int pick_reg(int mode);
        int start, r;
        start = $urandom % NREG;
        for (int k = 0; k < NREG; k++) begin
            r = (start + k) % NREG;
            if (mode == 0 && (m_wr[r] || m_busy[r])) return r;
            if (mode == 1 && !m_busy[r] && m_rd_cnt[r] == 0 && !m_wr[r]) return r;
            if (mode == 2 && !m_busy[r] && m_rd_cnt[r] == 0) return r;
        end
        return -1;
    endfunction

    function automatic int free_dest();
        int d;
        d = pick_reg(1);
        if (d < 0) d = pick_reg(2);
        return d;
    endfunction

    function automatic int find_val(uop_pkg::xlen_t v);
        for (int r = 0; r < NREG; r++) begin
            if (m_wr[r] && !m_busy[r] && m_val[r] == v) return r;
        end
        return -1;
    endfunction

    function automatic uop_pkg::xlen_t ext_data();
        case ($urandom % 8)
            0: return '0;
            1: return ONES;
            2: return MIN_INT;
            3: return $urandom % 16;
            default: return $urandom;
        endcase
    endfunction

    // ------------------------------
    // result checking
    // ------------------------------

    // at most one outstanding uop sits in fu_md
    task automatic check_room();
        int n_out;
        n_out = n_acc - n_done;
        if (n_out <= DEPTH - LANES) begin
            check_flag("ds_ready with free slots", 1'b1, ds_ready);
        end
        if (n_out >= DEPTH) begin
            check_flag("ds_ready with full station", 1'b0, ds_ready);
        end
    endtask

    task automatic observe_results();
        int r;
        uop_pkg::xlen_t exp, a, b;
        check_room();
        check_flag("ext_grant", ext_valid, ext_grant);
        if (ext_valid) check_flag("cdb_valid on ext write", 1'b1, cdb_valid);
        if (cdb_valid && ext_valid) begin
            check_tag("ext rob", ext_rob, cdb_rob);
            check_phy("ext phy", ext_phy, cdb_phy);
            check_arch("ext arch", ext_arch, cdb_arch);
            check_value("ext value", ext_value, cdb_value);
            m_val[ext_phy]  = ext_value;
            m_wr[ext_phy]   = 1'b1;
            m_busy[ext_phy] = 1'b0;
            n_ext_done++;
        end else if (cdb_valid) begin
            r = cdb_rob;
            if (!rob_used[r]) fail_run("fu_md result with an unknown or repeated ROB tag");
            a   = m_val[sb_s1[r]];
            b   = m_val[sb_s2[r]];
            exp = md_result(sb_op[r], a, b);
            if (sb_op[r] inside {exec_pkg::DIV, exec_pkg::REM, exec_pkg::DIVU, exec_pkg::REMU}
                    && b == 0) hit_div0 = 1'b1;
            if (sb_op[r] inside {exec_pkg::DIV, exec_pkg::REM} && a == MIN_INT && b == ONES)
                hit_ovf = 1'b1;
            check_phy("fu rd_phy", sb_rd[r], cdb_phy);
            check_arch("fu rd_arch", sb_arch[r], cdb_arch);
            check_value($sformatf("fu %s", sb_op[r].name()), exp, cdb_value);
            m_val[sb_rd[r]]  = exp;
            m_wr[sb_rd[r]]   = 1'b1;
            m_busy[sb_rd[r]] = 1'b0;
            m_rd_cnt[sb_s1[r]]--;
            m_rd_cnt[sb_s2[r]]--;
            rob_used[r] = 1'b0;
            n_done++;
        end
    endtask

    // ------------------------------
    // stimulus
    // ------------------------------

    task automatic build_lane(int j);
        int rb, s1, s2, d;
        exec_pkg::md_op_t op;
        rb = -1;
        for (int k = 0; k < NROB; k++) begin
            if (!rob_used[k] && rb < 0) rb = k;
        end
        s1 = -1;
        s2 = -1;
        op = exec_pkg::md_op_t'($urandom % 7);
        // first uops aim at the divide corner cases
        if (n_built < 14) begin
            op = exec_pkg::md_op_t'(n_built % 7);
            s1 = find_val(MIN_INT);
            s2 = find_val(n_built < 7 ? ONES : '0);
        end
        if (s1 < 0) s1 = pick_reg(0);
        if (s2 < 0) s2 = pick_reg(0);
        ds_valid[j] <= 1'b0;
        if (rb < 0 || s1 < 0 || s2 < 0 || n_built >= N_UOPS) return;
        m_rd_cnt[s1]++;
        m_rd_cnt[s2]++;
        d = free_dest();
        if (d < 0) begin
            m_rd_cnt[s1]--;
            m_rd_cnt[s2]--;
            return;
        end
        rob_used[rb] = 1'b1;
        m_busy[d]    = 1'b1;
        sb_op[rb]    = op;
        sb_s1[rb]    = s1;
        sb_s2[rb]    = s2;
        sb_rd[rb]    = d;
        sb_arch[rb]  = uop_pkg::arch_t'($urandom);
        n_built++;
        ds_valid[j]   <= 1'b1;
        ds_rob[j]     <= uop_pkg::rob_t'(rb);
        ds_op[j]      <= op;
        ds_rd_phy[j]  <= uop_pkg::phy_t'(d);
        ds_rd_arch[j] <= sb_arch[rb];
        ds_rs1_phy[j] <= uop_pkg::phy_t'(s1);
        ds_rs2_phy[j] <= uop_pkg::phy_t'(s2);
        ds_rs1_rdy[j] <= src_ready(s1);
        ds_rs2_rdy[j] <= src_ready(s2);
    endtask

    task automatic drive_step();
        bit pend;
        int p;
        pend = 1'b0;
        for (int j = 0; j < LANES; j++) begin
            if (ds_valid[j] && !ds_ready) pend = 1'b1;
            if (ds_valid[j] && ds_ready) n_acc++;
        end
        if (!ds_ready) saw_low = 1'b1;
        // the first three external writes seed the corner values
        ext_valid <= 1'b0;
        if (n_ext_sent < 3 || (n_built >= 14 && n_built < N_UOPS && $urandom % 8 == 0)) begin
            p = free_dest();
            if (p >= 0) begin
                m_busy[p] = 1'b1;
                ext_valid <= 1'b1;
                ext_phy   <= uop_pkg::phy_t'(p);
                ext_rob   <= uop_pkg::rob_t'($urandom);
                ext_arch  <= uop_pkg::arch_t'($urandom);
                ext_value <= (n_ext_sent == 0) ? MIN_INT
                           : (n_ext_sent == 1) ? ONES
                           : (n_ext_sent == 2) ? '0 : ext_data();
                n_ext_sent++;
            end
        end
        if (pend) begin
            // refresh readiness of a held group from the model
            for (int j = 0; j < LANES; j++) begin
                ds_rs1_rdy[j] <= src_ready(sb_s1[ds_rob[j]]);
                ds_rs2_rdy[j] <= src_ready(sb_s2[ds_rob[j]]);
            end
        end else if (n_ext_done >= 3 && $urandom % 4 != 0) begin
            for (int j = 0; j < LANES; j++) build_lane(j);
        end else begin
            for (int j = 0; j < LANES; j++) ds_valid[j] <= 1'b0;
        end
    endtask

    initial begin
        void'($urandom(66004));
        rst       = 1'b1;
        ext_valid = 1'b0;
        ext_phy   = '0;
        ext_rob   = '0;
        ext_arch  = '0;
        ext_value = '0;
        for (int j = 0; j < LANES; j++) begin
            ds_valid[j]   = 1'b0;
            ds_rob[j]     = '0;
            ds_rd_phy[j]  = '0;
            ds_rd_arch[j] = '0;
            ds_rs1_phy[j] = '0;
            ds_rs1_rdy[j] = 1'b0;
            ds_rs2_phy[j] = '0;
            ds_rs2_rdy[j] = 1'b0;
            ds_op[j]      = exec_pkg::MUL;
        end
        for (int r = 0; r < NREG; r++) begin
            m_val[r]    = '0;
            m_wr[r]     = 1'b0;
            m_busy[r]   = 1'b0;
            m_rd_cnt[r] = 0;
        end
        for (int k = 0; k < NROB; k++) rob_used[k] = 1'b0;
        n_built    = 0;
        n_done     = 0;
        n_ext_sent = 0;
        n_ext_done = 0;
        n_acc      = 0;
        saw_low    = 1'b0;
        hit_div0   = 1'b0;
        hit_ovf    = 1'b0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_flag("ds_ready after reset", 1'b1, ds_ready);
        check_flag("cdb_valid after reset", 1'b0, cdb_valid);
        while (n_done < N_UOPS) begin
            @(posedge clk);
            observe_results();
            drive_step();
        end
        if (saw_low && hit_div0 && hit_ovf) begin
            $display("TB PASSED");
            $finish;
        end else begin
            fail_run("divide corner cases or ds_ready back-pressure were never exercised");
        end
    end

endmodule

//--- intm_properties.sv
`timescale 1ns/1ns

module intm_properties (
    input logic           clk,
    input logic           rst,
    input logic           ext_valid,
    input logic           ext_grant,
    input logic           ds_ready,
    input logic           fu_valid,
    input logic           fu_ready,
    input uop_pkg::xlen_t fu_value
);

    // grant only for a request
    assert property (@(posedge clk) disable iff (rst) ext_grant |-> ext_valid)
        else $error("ext_grant without ext_valid");

    // empty station right after reset
    assert property (@(posedge clk) $past(rst) && !rst |-> ds_ready)
        else $error("ds_ready low after reset");

    // an ungranted fu_md result stays put
    assert property (@(posedge clk) disable iff (rst)
            fu_valid && !fu_ready |=> fu_valid && $stable(fu_value))
        else $error("held fu_md result changed before grant");

endmodule

bind intm_top intm_properties u_props (
    .clk, .rst, .ext_valid, .ext_grant, .ds_ready,
    .fu_valid(fu_res.valid), .fu_ready, .fu_value(fu_res.value)
);

//--- intm_top.sv
`timescale 1ns/1ns
`include "intm_cfg.svh"

module intm_top (
    input  logic             clk,
    input  logic             rst,
    input  logic             ds_valid   [`INTM_ID_WIDTH],
    input  uop_pkg::rob_t    ds_rob     [`INTM_ID_WIDTH],
    input  uop_pkg::phy_t    ds_rd_phy  [`INTM_ID_WIDTH],
    input  uop_pkg::arch_t   ds_rd_arch [`INTM_ID_WIDTH],
    input  uop_pkg::phy_t    ds_rs1_phy [`INTM_ID_WIDTH],
    input  logic             ds_rs1_rdy [`INTM_ID_WIDTH],
    input  uop_pkg::phy_t    ds_rs2_phy [`INTM_ID_WIDTH],
    input  logic             ds_rs2_rdy [`INTM_ID_WIDTH],
    input  exec_pkg::md_op_t ds_op      [`INTM_ID_WIDTH],
    output logic             ds_ready,
    input  logic             ext_valid,
    input  uop_pkg::phy_t    ext_phy,
    input  uop_pkg::rob_t    ext_rob,
    input  uop_pkg::arch_t   ext_arch,
    input  uop_pkg::xlen_t   ext_value,
    output logic             ext_grant,
    output logic             cdb_valid,
    output uop_pkg::phy_t    cdb_phy,
    output uop_pkg::rob_t    cdb_rob,
    output uop_pkg::arch_t   cdb_arch,
    output uop_pkg::xlen_t   cdb_value
);

    // fu_md result and the arbitrated bus
    cdb_if fu_res ();
    cdb_if cdb_bus ();

    uop_pkg::phy_t    rd1_phy, rd2_phy, iss_rd_phy;
    uop_pkg::xlen_t   rd1_value, rd2_value, iss_a, iss_b;
    uop_pkg::rob_t    iss_rob;
    uop_pkg::arch_t   iss_rd_arch;
    exec_pkg::md_op_t iss_op;
    logic             iss_valid, iss_ready, fu_ready;

    intm_rs u_rs (
        .clk, .rst, .ds_valid, .ds_rob, .ds_rd_phy, .ds_rd_arch,
        .ds_rs1_phy, .ds_rs1_rdy, .ds_rs2_phy, .ds_rs2_rdy, .ds_op, .ds_ready,
        .cdb(cdb_bus), .rd1_phy, .rd2_phy, .rd1_value, .rd2_value,
        .iss_valid, .iss_ready, .iss_op, .iss_rob, .iss_rd_phy, .iss_rd_arch,
        .iss_a, .iss_b
    );

    prf u_prf (
        .clk, .rst, .cdb(cdb_bus), .rd1_phy, .rd2_phy, .rd1_value, .rd2_value
    );

    fu_md u_fu_md (
        .clk, .rst, .prv_valid(iss_valid), .prv_ready(iss_ready), .op(iss_op),
        .rob(iss_rob), .rd_phy(iss_rd_phy), .rd_arch(iss_rd_arch), .a(iss_a), .b(iss_b),
        .res(fu_res), .res_ready(fu_ready)
    );

    cdb_arb u_arb (
        .ext_valid, .ext_phy, .ext_rob, .ext_arch, .ext_value, .ext_grant,
        .fu(fu_res), .fu_ready, .bus(cdb_bus)
    );

    assign cdb_valid = cdb_bus.valid;
    assign cdb_phy   = cdb_bus.phy;
    assign cdb_rob   = cdb_bus.rob;
    assign cdb_arch  = cdb_bus.arch;
    assign cdb_value = cdb_bus.value;

endmodule

//--- cdb_arb.sv
`timescale 1ns/1ns

module cdb_arb (
    input  logic           ext_valid,
    input  uop_pkg::phy_t  ext_phy,
    input  uop_pkg::rob_t  ext_rob,
    input  uop_pkg::arch_t ext_arch,
    input  uop_pkg::xlen_t ext_value,
    output logic           ext_grant,
    cdb_if.snoop           fu,
    output logic           fu_ready,
    cdb_if.arb             bus
);

    // external port never waits
    assign ext_grant = ext_valid;
    assign fu_ready  = !ext_valid;

    // winner onto the single lane
    always_comb begin
        if (ext_valid) begin
            bus.valid = 1'b1;
            bus.phy   = ext_phy;
            bus.rob   = ext_rob;
            bus.arch  = ext_arch;
            bus.value = ext_value;
        end else begin
            bus.valid = fu.valid;
            bus.phy   = fu.phy;
            bus.rob   = fu.rob;
            bus.arch  = fu.arch;
            bus.value = fu.value;
        end
    end

endmodule

//--- prf.sv
`timescale 1ns/1ns
`include "intm_cfg.svh"

module prf (
    input  logic           clk,
    input  logic           rst,
    cdb_if.snoop           cdb,
    input  uop_pkg::phy_t  rd1_phy,
    input  uop_pkg::phy_t  rd2_phy,
    output uop_pkg::xlen_t rd1_value,
    output uop_pkg::xlen_t rd2_value
);

    uop_pkg::xlen_t regs    [`INTM_PRF_REGS];
    logic           written [`INTM_PRF_REGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `INTM_PRF_REGS; i++) begin
                written[i] <= 1'b0;
            end
        end else if (cdb.valid) begin
            written[cdb.phy] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (cdb.valid) regs[cdb.phy] <= cdb.value;
    end

    // same-cycle bus write wins, unwritten registers read as zero
    assign rd1_value = (cdb.valid && cdb.phy == rd1_phy) ? cdb.value
                     : (written[rd1_phy] ? regs[rd1_phy] : '0);
    assign rd2_value = (cdb.valid && cdb.phy == rd2_phy) ? cdb.value
                     : (written[rd2_phy] ? regs[rd2_phy] : '0);

endmodule

//--- fu_md.sv
`timescale 1ns/1ns
`include "intm_cfg.svh"

module fu_md (
    input  logic             clk,
    input  logic             rst,
    input  logic             prv_valid,
    output logic             prv_ready,
    input  exec_pkg::md_op_t op,
    input  uop_pkg::rob_t    rob,
    input  uop_pkg::phy_t    rd_phy,
    input  uop_pkg::arch_t   rd_arch,
    input  uop_pkg::xlen_t   a,
    input  uop_pkg::xlen_t   b,
    cdb_if.src               res,
    input  logic             res_ready
);

    localparam int XLEN = `INTM_XLEN;

    exec_pkg::md_state_t  state;
    exec_pkg::md_op_t     op_q;
    exec_pkg::div_cnt_t   cnt;
    uop_pkg::rob_t        rob_q;
    uop_pkg::phy_t        rd_phy_q;
    uop_pkg::arch_t       rd_arch_q;
    uop_pkg::xlen_t       rem, quo, divisor, rem_next, quo_next, div_value, res_value;
    logic signed [XLEN:0]     mul_a, mul_b;
    logic signed [2*XLEN+1:0] product;
    logic [XLEN:0]        rem_shift, diff;
    logic                 is_mul, signed_op, neg_q, neg_r;

    assign is_mul    = op inside {exec_pkg::MUL, exec_pkg::MULH, exec_pkg::MULHU};
    assign signed_op = op inside {exec_pkg::MULH, exec_pkg::DIV, exec_pkg::REM};

    // second multiplier stage, exact 33x33 product
    assign product = mul_a * mul_b;

    // one restoring step on magnitudes
    assign rem_shift = {rem, quo[XLEN-1]};
    assign diff      = rem_shift - {1'b0, divisor};
    assign rem_next  = diff[XLEN] ? rem_shift[XLEN-1:0] : diff[XLEN-1:0];
    assign quo_next  = {quo[XLEN-2:0], ~diff[XLEN]};

    // sign correction, zero divisor leaves the all-ones quotient alone
    always_comb begin
        if (op_q == exec_pkg::REM || op_q == exec_pkg::REMU) begin
            div_value = neg_r ? -rem_next : rem_next;
        end else begin
            div_value = neg_q ? -quo_next : quo_next;
        end
    end

    // ------------------------------
    // control
    // ------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= exec_pkg::IDLE;
        end else begin
            case (state)
                exec_pkg::IDLE: begin
                    if (prv_valid && is_mul) state <= exec_pkg::MUL_BUSY;
                    else if (prv_valid) state <= exec_pkg::DIV_BUSY;
                end
                exec_pkg::MUL_BUSY: state <= exec_pkg::DONE;
                exec_pkg::DIV_BUSY: if (cnt == exec_pkg::div_cnt_t'(1)) state <= exec_pkg::DONE;
                // hold until the arbiter takes it
                default: if (res_ready) state <= exec_pkg::IDLE;
            endcase
        end
    end

    // ------------------------------
    // datapath
    // ------------------------------

    always_ff @(posedge clk) begin
        case (state)
            exec_pkg::IDLE: begin
                if (prv_valid) begin
                    op_q      <= op;
                    rob_q     <= rob;
                    rd_phy_q  <= rd_phy;
                    rd_arch_q <= rd_arch;
                    mul_a     <= {signed_op && a[XLEN-1], a};
                    mul_b     <= {signed_op && b[XLEN-1], b};
                    rem       <= '0;
                    quo       <= (signed_op && a[XLEN-1]) ? -a : a;
                    divisor   <= (signed_op && b[XLEN-1]) ? -b : b;
                    neg_q     <= signed_op && (a[XLEN-1] ^ b[XLEN-1]) && (b != '0);
                    neg_r     <= signed_op && a[XLEN-1];
                    cnt       <= exec_pkg::div_cnt_t'(XLEN);
                end
            end
            exec_pkg::MUL_BUSY: begin
                if (op_q == exec_pkg::MUL) res_value <= product[XLEN-1:0];
                else res_value <= product[2*XLEN-1:XLEN];
            end
            exec_pkg::DIV_BUSY: begin
                rem <= rem_next;
                quo <= quo_next;
                cnt <= cnt - exec_pkg::div_cnt_t'(1);
                if (cnt == exec_pkg::div_cnt_t'(1)) res_value <= div_value;
            end
            default: ;
        endcase
    end

    assign prv_ready = (state == exec_pkg::IDLE);
    assign res.valid = (state == exec_pkg::DONE);
    assign res.phy   = rd_phy_q;
    assign res.rob   = rob_q;
    assign res.arch  = rd_arch_q;
    assign res.value = res_value;

endmodule

//--- intm_rs.sv
`timescale 1ns/1ns
`include "intm_cfg.svh"

module intm_rs (
    input  logic                clk,
    input  logic                rst,
    input  logic                ds_valid   [`INTM_ID_WIDTH],
    input  uop_pkg::rob_t       ds_rob     [`INTM_ID_WIDTH],
    input  uop_pkg::phy_t       ds_rd_phy  [`INTM_ID_WIDTH],
    input  uop_pkg::arch_t      ds_rd_arch [`INTM_ID_WIDTH],
    input  uop_pkg::phy_t       ds_rs1_phy [`INTM_ID_WIDTH],
    input  logic                ds_rs1_rdy [`INTM_ID_WIDTH],
    input  uop_pkg::phy_t       ds_rs2_phy [`INTM_ID_WIDTH],
    input  logic                ds_rs2_rdy [`INTM_ID_WIDTH],
    input  exec_pkg::md_op_t    ds_op      [`INTM_ID_WIDTH],
    output logic                ds_ready,
    cdb_if.snoop                cdb,
    output uop_pkg::phy_t       rd1_phy,
    output uop_pkg::phy_t       rd2_phy,
    input  uop_pkg::xlen_t      rd1_value,
    input  uop_pkg::xlen_t      rd2_value,
    output logic                iss_valid,
    input  logic                iss_ready,
    output exec_pkg::md_op_t    iss_op,
    output uop_pkg::rob_t       iss_rob,
    output uop_pkg::phy_t       iss_rd_phy,
    output uop_pkg::arch_t      iss_rd_arch,
    output uop_pkg::xlen_t      iss_a,
    output uop_pkg::xlen_t      iss_b
);

    localparam int DEPTH = `INTM_RS_DEPTH;
    localparam int LANES = `INTM_ID_WIDTH;

    typedef struct packed {
        uop_pkg::rob_t    rob;
        uop_pkg::phy_t    rs1_phy;
        logic             rs1_rdy;
        uop_pkg::phy_t    rs2_phy;
        logic             rs2_rdy;
        uop_pkg::phy_t    rd_phy;
        uop_pkg::arch_t   rd_arch;
        exec_pkg::md_op_t op;
    } entry_t;

    // one extra bit so a full station reads DEPTH
    typedef logic [$bits(uop_pkg::rs_idx_t):0] top_t;

    entry_t                   slot       [DEPTH];
    entry_t                   slot_woken [DEPTH];
    entry_t                   slot_next  [DEPTH];
    entry_t                   lane_woken [LANES];
    exec_pkg::rs_update_sel_t upd_sel    [DEPTH];
    logic [$clog2(LANES)-1:0] push_lane  [DEPTH];
    logic                     push_en    [LANES];
    top_t                     push_pos   [LANES];
    top_t                     top, top_pop, top_next;
    uop_pkg::rs_idx_t         sel_idx;
    logic                     issue_fire;

    // set a source ready when the CDB carries its tag
    function automatic entry_t wake(entry_t e, logic hit, uop_pkg::phy_t hit_phy);
        entry_t w;
        w = e;
        if (hit && e.rs1_phy == hit_phy) w.rs1_rdy = 1'b1;
        if (hit && e.rs2_phy == hit_phy) w.rs2_rdy = 1'b1;
        return w;
    endfunction

    // ------------------------------
    // wakeup and select
    // ------------------------------

    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            slot_woken[i] = wake(slot[i], cdb.valid, cdb.phy);
        end
        // a uop arriving with a source on the bus right now
        for (int j = 0; j < LANES; j++) begin
            lane_woken[j] = wake('{rob: ds_rob[j], rs1_phy: ds_rs1_phy[j],
                                   rs1_rdy: ds_rs1_rdy[j], rs2_phy: ds_rs2_phy[j],
                                   rs2_rdy: ds_rs2_rdy[j], rd_phy: ds_rd_phy[j],
                                   rd_arch: ds_rd_arch[j], op: ds_op[j]},
                                 cdb.valid, cdb.phy);
        end
    end

    // oldest ready wins, slot 0 is the oldest
    always_comb begin
        iss_valid = 1'b0;
        sel_idx   = '0;
        for (int i = 0; i < DEPTH; i++) begin
            if (!iss_valid && top_t'(i) < top
                    && slot_woken[i].rs1_rdy && slot_woken[i].rs2_rdy) begin
                iss_valid = 1'b1;
                sel_idx   = uop_pkg::rs_idx_t'(i);
            end
        end
    end

    assign issue_fire = iss_valid && iss_ready;

    // ------------------------------
    // pop, push and compress
    // ------------------------------

    always_comb begin
        top_pop  = top - top_t'(issue_fire);
        top_next = top_pop;
        for (int j = 0; j < LANES; j++) begin
            push_en[j]  = ds_valid[j] && ds_ready;
            push_pos[j] = top_next;
            if (push_en[j]) top_next = top_next + top_t'(1);
        end
    end

    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            upd_sel[i]   = exec_pkg::SELF;
            push_lane[i] = '0;
            if (issue_fire && uop_pkg::rs_idx_t'(i) >= sel_idx) upd_sel[i] = exec_pkg::PREV;
            for (int j = 0; j < LANES; j++) begin
                if (push_en[j] && push_pos[j] == top_t'(i)) begin
                    upd_sel[i]   = exec_pkg::PUSH_IN;
                    push_lane[i] = ($clog2(LANES))'(j);
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            case (upd_sel[i])
                // the top slot wraps here but falls outside the new top
                exec_pkg::PREV:    slot_next[i] = slot_woken[(i + 1) % DEPTH];
                exec_pkg::PUSH_IN: slot_next[i] = lane_woken[push_lane[i]];
                default:           slot_next[i] = slot_woken[i];
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            top <= '0;
        end else begin
            top <= top_next;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < DEPTH; i++) begin
            slot[i] <= slot_next[i];
        end
    end

    // room for a full dispatch group
    assign ds_ready = (top <= top_t'(DEPTH - LANES));

    // ------------------------------
    // operand fetch and issue
    // ------------------------------

    assign rd1_phy     = slot[sel_idx].rs1_phy;
    assign rd2_phy     = slot[sel_idx].rs2_phy;
    assign iss_op      = slot[sel_idx].op;
    assign iss_rob     = slot[sel_idx].rob;
    assign iss_rd_phy  = slot[sel_idx].rd_phy;
    assign iss_rd_arch = slot[sel_idx].rd_arch;
    assign iss_a       = rd1_value;
    assign iss_b       = rd2_value;

endmodule

//--- cdb_if.sv
`timescale 1ns/1ns

// one lane of the common data bus
interface cdb_if;

    logic           valid;
    uop_pkg::phy_t  phy;
    uop_pkg::rob_t  rob;
    uop_pkg::arch_t arch;
    uop_pkg::xlen_t value;

    // a producer presenting a result
    modport src (output valid, phy, rob, arch, value);

    // the arbiter driving the shared bus
    modport arb (output valid, phy, rob, arch, value);

    // consumers watching the bus, or the arbiter reading a producer
    modport snoop (input valid, phy, rob, arch, value);

endinterface

//--- exec_pkg.sv
`include "intm_cfg.svh"

package exec_pkg;

    // mul/div function codes
    typedef enum logic [3:0] {
        MUL   = 4'd0,
        MULH  = 4'd1,
        MULHU = 4'd2,
        DIV   = 4'd3,
        DIVU  = 4'd4,
        REM   = 4'd5,
        REMU  = 4'd6
    } md_op_t;

    // fu_md sequencing
    typedef enum logic [1:0] {IDLE, MUL_BUSY, DIV_BUSY, DONE} md_state_t;

    // where a station slot takes its next content from
    typedef enum logic [1:0] {SELF, PREV, PUSH_IN} rs_update_sel_t;

    // divider step counter, counts XLEN steps down to one
    typedef logic [$clog2(`INTM_XLEN+1)-1:0] div_cnt_t;

endpackage

//--- uop_pkg.sv
`include "intm_cfg.svh"

package uop_pkg;

    // ------------------------------
    // register names
    // ------------------------------

    // physical register index
    typedef logic [$clog2(`INTM_PRF_REGS)-1:0] phy_t;

    // architectural register index, x0..x31
    typedef logic [4:0] arch_t;

    // ------------------------------
    // micro-op fields
    // ------------------------------

    // reorder buffer tag carried to the CDB
    typedef logic [$clog2(`INTM_ROB_SIZE)-1:0] rob_t;

    // one data word
    typedef logic [`INTM_XLEN-1:0] xlen_t;

    // slot position inside the station
    typedef logic [$clog2(`INTM_RS_DEPTH)-1:0] rs_idx_t;

endpackage

//--- intm_cfg.svh
`ifndef INTM_CFG_SVH
`define INTM_CFG_SVH

// ------------------------------
// sizing of the mul/div issue path
// ------------------------------

// reservation station slots
`define INTM_RS_DEPTH 8

// uops delivered per dispatch cycle
`define INTM_ID_WIDTH 2

// physical registers behind the CDB
`define INTM_PRF_REGS 32

// reorder buffer entries, sets the tag width
`define INTM_ROB_SIZE 16

// integer datapath width
`define INTM_XLEN 32

`endif
